//--- hdl/rvConfig_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// integer register and address width
`define RV_XLEN 64

// first fetch address out of reset
`define RV_RESET_PC 64'h0000_0000_8000_0000

// architectural integer registers, x0 included
`define RV_NREGS 32

`endif

//--- hdl/rvPkg.sv
package rvPkg;

    typedef logic [63:0] xlenT;
    typedef logic [31:0] instT;
    typedef logic [7:0] byteMaskT;

    // major opcodes handled by this core
    typedef enum logic [6:0] {
        opLoad    = 7'b0000011,
        opOpImm   = 7'b0010011,
        opAuipc   = 7'b0010111,
        opOpImmW  = 7'b0011011,
        opStore   = 7'b0100011,
        opOp      = 7'b0110011,
        opLui     = 7'b0110111,
        opOpW     = 7'b0111011,
        opBranch  = 7'b1100011,
        opJalr    = 7'b1100111,
        opJal     = 7'b1101111,
        opSystem  = 7'b1110011
    } opcodeE;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
        aluSrl, aluSra, aluOr, aluAnd, aluPassB
    } aluOpE;

    // next-pc rule for the current instruction
    typedef enum logic [3:0] {
        brNone, brJal, brJalr, brBeq, brBne,
        brBlt, brBge, brBltu, brBgeu
    } branchE;

    // encoding follows funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        memByte, memHalf, memWord, memDouble
    } memSizeE;

    typedef enum logic [1:0] {
        wbAlu, wbMem, wbPcPlus4
    } wbSrcE;

endpackage

//--- hdl/decodeIf.sv
interface decodeIf;
    rvPkg::aluOpE aluOp;
    // pc instead of rs1
    logic aluSrcA;
    // immediate instead of rs2
    logic aluSrcB;
    logic isWord;
    rvPkg::branchE branch;
    rvPkg::xlenT imm;
    logic regWrite;
    logic memRead;
    logic memWrite;
    rvPkg::memSizeE memSize;
    logic memUnsigned;
    rvPkg::wbSrcE wbSrc;
    logic isEbreak;

    modport dec (
        output aluOp, aluSrcA, aluSrcB, isWord, branch, imm, regWrite,
        output memRead, memWrite, memSize, memUnsigned, wbSrc, isEbreak
    );
    modport exe (input aluOp, aluSrcA, aluSrcB, isWord, branch, imm);
    modport mem (input memRead, memWrite, memSize, memUnsigned, wbSrc, regWrite);
    modport fch (input isEbreak);
endinterface

//--- hdl/fetchUnit.sv
`include "rvConfig_config.svh"

module fetchUnit (
    input  logic         clk,
    input  logic         arstN,
    decodeIf.fch         dc,
    input  logic         taken,
    input  rvPkg::xlenT  target,
    input  rvPkg::xlenT  imemData,
    output rvPkg::xlenT  imemAddr,
    output rvPkg::xlenT  pc,
    output rvPkg::instT  inst,
    output logic         halt
);
    rvPkg::xlenT nextPc;

    // memory is addressed in whole 64-bit words
    assign imemAddr = {pc[`RV_XLEN-1:3], 3'b000};

    // pc bit 2 picks the upper instruction of the word
    assign inst = pc[2] ? imemData[63:32] : imemData[31:0];

    always_comb begin
        if (halt || dc.isEbreak) begin
            // ebreak freezes the pc on itself
            nextPc = pc;
        end else if (taken) begin
            nextPc = target;
        end else begin
            nextPc = pc + 'd4;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

    // halt is sticky until the next reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            halt <= 1'b0;
        end else if (dc.isEbreak) begin
            halt <= 1'b1;
        end
    end

endmodule

//--- hdl/instDecoder.sv
module instDecoder (
    input rvPkg::instT inst,
    decodeIf.dec       dc
);
    rvPkg::opcodeE opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    rvPkg::xlenT immI;
    rvPkg::xlenT immS;
    rvPkg::xlenT immB;
    rvPkg::xlenT immU;
    rvPkg::xlenT immJ;
    rvPkg::aluOpE funcOp;

    assign opcode = rvPkg::opcodeE'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // immediates, all sign-extended from inst[31]
    assign immI = {{52{inst[31]}}, inst[31:20]};
    assign immS = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign immJ = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // funct3 map shared by register and immediate forms;
    // opcode bit 5 separates OP from OP-IMM, so addi never turns into sub
    always_comb begin
        case (funct3)
            3'b000:  funcOp = (opcode[5] && funct7[5]) ? rvPkg::aluSub : rvPkg::aluAdd;
            3'b001:  funcOp = rvPkg::aluSll;
            3'b010:  funcOp = rvPkg::aluSlt;
            3'b011:  funcOp = rvPkg::aluSltu;
            3'b100:  funcOp = rvPkg::aluXor;
            3'b101:  funcOp = funct7[5] ? rvPkg::aluSra : rvPkg::aluSrl;
            3'b110:  funcOp = rvPkg::aluOr;
            default: funcOp = rvPkg::aluAnd;
        endcase
    end

    always_comb begin
        // defaults describe a harmless no-op
        dc.aluOp       = rvPkg::aluAdd;
        dc.aluSrcA     = 1'b0;
        dc.aluSrcB     = 1'b0;
        dc.isWord      = 1'b0;
        dc.branch      = rvPkg::brNone;
        dc.imm         = immI;
        dc.regWrite    = 1'b0;
        dc.memRead     = 1'b0;
        dc.memWrite    = 1'b0;
        dc.memSize     = rvPkg::memSizeE'(funct3[1:0]);
        dc.memUnsigned = funct3[2];
        dc.wbSrc       = rvPkg::wbAlu;
        dc.isEbreak    = 1'b0;
        case (opcode)
            rvPkg::opLui: begin
                dc.imm      = immU;
                dc.aluOp    = rvPkg::aluPassB;
                dc.aluSrcB  = 1'b1;
                dc.regWrite = 1'b1;
            end
            rvPkg::opAuipc: begin
                dc.imm      = immU;
                dc.aluSrcA  = 1'b1;
                dc.aluSrcB  = 1'b1;
                dc.regWrite = 1'b1;
            end
            rvPkg::opJal: begin
                dc.imm      = immJ;
                dc.branch   = rvPkg::brJal;
                dc.regWrite = 1'b1;
                dc.wbSrc    = rvPkg::wbPcPlus4;
            end
            rvPkg::opJalr: begin
                dc.branch   = rvPkg::brJalr;
                dc.regWrite = 1'b1;
                dc.wbSrc    = rvPkg::wbPcPlus4;
            end
            rvPkg::opBranch: begin
                dc.imm = immB;
                case (funct3)
                    3'b000:  dc.branch = rvPkg::brBeq;
                    3'b001:  dc.branch = rvPkg::brBne;
                    3'b100:  dc.branch = rvPkg::brBlt;
                    3'b101:  dc.branch = rvPkg::brBge;
                    3'b110:  dc.branch = rvPkg::brBltu;
                    3'b111:  dc.branch = rvPkg::brBgeu;
                    default: dc.branch = rvPkg::brNone;
                endcase
            end
            rvPkg::opLoad: begin
                dc.aluSrcB  = 1'b1;
                dc.regWrite = 1'b1;
                dc.memRead  = 1'b1;
                dc.wbSrc    = rvPkg::wbMem;
            end
            rvPkg::opStore: begin
                dc.imm      = immS;
                dc.aluSrcB  = 1'b1;
                dc.memWrite = 1'b1;
            end
            rvPkg::opOpImm, rvPkg::opOpImmW: begin
                dc.aluOp    = funcOp;
                dc.aluSrcB  = 1'b1;
                dc.isWord   = (opcode == rvPkg::opOpImmW);
                dc.regWrite = 1'b1;
            end
            rvPkg::opOp, rvPkg::opOpW: begin
                dc.aluOp    = funcOp;
                dc.isWord   = (opcode == rvPkg::opOpW);
                dc.regWrite = 1'b1;
            end
            rvPkg::opSystem: begin
                dc.isEbreak = (inst == 32'h0010_0073);
            end
            default: begin
            end
        endcase
    end

endmodule

//--- hdl/regFile.sv
`include "rvConfig_config.svh"

module regFile (
    input  logic         clk,
    input  logic         arstN,
    input  logic [4:0]   rs1,
    input  logic [4:0]   rs2,
    input  logic [4:0]   rd,
    input  rvPkg::xlenT  wdata,
    input  logic         wen,
    output rvPkg::xlenT  rdata1,
    output rvPkg::xlenT  rdata2
);
    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    // contents survive reset, only the write is blocked
    always_ff @(posedge clk) begin
        if (wen && arstN && (rd != 5'd0)) begin
            regs[rd] <= wdata;
        end
    end

    // x0 never reads back what sits in its slot
    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- hdl/execUnit.sv
`include "rvConfig_config.svh"

module execUnit (
    decodeIf.exe         dc,
    input  rvPkg::xlenT  pc,
    input  rvPkg::xlenT  rs1Val,
    input  rvPkg::xlenT  rs2Val,
    output rvPkg::xlenT  aluResult,
    output logic         taken,
    output rvPkg::xlenT  target
);
    rvPkg::xlenT opA;
    rvPkg::xlenT opB;
    rvPkg::xlenT shiftIn;
    rvPkg::xlenT rawResult;
    rvPkg::xlenT jalrSum;
    logic [5:0] shamt;
    logic isEq;
    logic isLt;
    logic isLtu;

    assign opA = dc.aluSrcA ? pc : rs1Val;
    assign opB = dc.aluSrcB ? dc.imm : rs2Val;

    // word ops only look at 5 shift bits
    assign shamt = dc.isWord ? {1'b0, opB[4:0]} : opB[5:0];

    // word shifts act on the low half, extended to suit the right shift
    always_comb begin
        if (!dc.isWord) begin
            shiftIn = opA;
        end else if (dc.aluOp == rvPkg::aluSra) begin
            shiftIn = {{32{opA[31]}}, opA[31:0]};
        end else begin
            shiftIn = {32'b0, opA[31:0]};
        end
    end

    always_comb begin
        case (dc.aluOp)
            rvPkg::aluAdd:   rawResult = opA + opB;
            rvPkg::aluSub:   rawResult = opA - opB;
            rvPkg::aluSll:   rawResult = shiftIn << shamt;
            rvPkg::aluSlt:   rawResult = {{(`RV_XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            rvPkg::aluSltu:  rawResult = {{(`RV_XLEN-1){1'b0}}, opA < opB};
            rvPkg::aluXor:   rawResult = opA ^ opB;
            rvPkg::aluSrl:   rawResult = shiftIn >> shamt;
            rvPkg::aluSra:   rawResult = $signed(shiftIn) >>> shamt;
            rvPkg::aluOr:    rawResult = opA | opB;
            rvPkg::aluAnd:   rawResult = opA & opB;
            rvPkg::aluPassB: rawResult = opB;
            default:         rawResult = '0;
        endcase
    end

    assign aluResult = dc.isWord ? {{32{rawResult[31]}}, rawResult[31:0]} : rawResult;

    assign isEq  = (rs1Val == rs2Val);
    assign isLt  = ($signed(rs1Val) < $signed(rs2Val));
    assign isLtu = (rs1Val < rs2Val);

    always_comb begin
        case (dc.branch)
            rvPkg::brJal, rvPkg::brJalr: taken = 1'b1;
            rvPkg::brBeq:  taken = isEq;
            rvPkg::brBne:  taken = !isEq;
            rvPkg::brBlt:  taken = isLt;
            rvPkg::brBge:  taken = !isLt;
            rvPkg::brBltu: taken = isLtu;
            rvPkg::brBgeu: taken = !isLtu;
            default:       taken = 1'b0;
        endcase
    end

    // jalr target drops bit 0
    assign jalrSum = rs1Val + dc.imm;
    assign target  = (dc.branch == rvPkg::brJalr) ? {jalrSum[`RV_XLEN-1:1], 1'b0} : pc + dc.imm;

endmodule

//--- hdl/memWriteback.sv
`include "rvConfig_config.svh"

module memWriteback (
    decodeIf.mem              dc,
    input  logic              halt,
    input  rvPkg::xlenT       aluResult,
    input  rvPkg::xlenT       pc,
    input  rvPkg::xlenT       rs2Val,
    input  rvPkg::xlenT       dmemRdata,
    output rvPkg::xlenT       dmemAddr,
    output rvPkg::xlenT       dmemWdata,
    output rvPkg::byteMaskT   dmemWmask,
    output logic              dmemWen,
    output rvPkg::xlenT       rdWdata,
    output logic              rdWen
);
    logic [2:0] byteOff;
    logic [5:0] bitOff;
    rvPkg::byteMaskT sizeMask;
    rvPkg::xlenT laneData;
    rvPkg::xlenT loadVal;

    assign byteOff  = aluResult[2:0];
    assign bitOff   = {byteOff, 3'b000};
    // byte lanes come from the mask, so the bus address is word aligned
    assign dmemAddr = {aluResult[`RV_XLEN-1:3], 3'b000};

    always_comb begin
        case (dc.memSize)
            rvPkg::memByte: sizeMask = 8'h01;
            rvPkg::memHalf: sizeMask = 8'h03;
            rvPkg::memWord: sizeMask = 8'h0f;
            default:        sizeMask = 8'hff;
        endcase
    end

    assign dmemWmask = sizeMask << byteOff;
    assign dmemWdata = rs2Val << bitOff;
    assign dmemWen   = dc.memWrite && !halt;

    // loaded value moved down to lane 0 before extension
    assign laneData = dmemRdata >> bitOff;

    always_comb begin
        case (dc.memSize)
            rvPkg::memByte: loadVal = {{56{!dc.memUnsigned && laneData[7]}}, laneData[7:0]};
            rvPkg::memHalf: loadVal = {{48{!dc.memUnsigned && laneData[15]}}, laneData[15:0]};
            rvPkg::memWord: loadVal = {{32{!dc.memUnsigned && laneData[31]}}, laneData[31:0]};
            default:        loadVal = laneData;
        endcase
    end

    always_comb begin
        case (dc.wbSrc)
            rvPkg::wbMem:     rdWdata = dc.memRead ? loadVal : '0;
            rvPkg::wbPcPlus4: rdWdata = pc + 'd4;
            default:          rdWdata = aluResult;
        endcase
    end

    assign rdWen = dc.regWrite && !halt;

endmodule

//--- hdl/rvCore.sv
module rvCore (
    input  logic        clk,
    input  logic        arstN,
    output logic [63:0] imemAddr,
    input  logic [63:0] imemData,
    output logic [63:0] dmemAddr,
    output logic [63:0] dmemWdata,
    output logic [7:0]  dmemWmask,
    output logic        dmemWen,
    input  logic [63:0] dmemRdata,
    output logic [63:0] pc,
    output logic [31:0] inst,
    output logic        halt
);
    rvPkg::xlenT rs1Val;
    rvPkg::xlenT rs2Val;
    rvPkg::xlenT aluResult;
    rvPkg::xlenT target;
    rvPkg::xlenT rdWdata;
    logic taken;
    logic rdWen;
    logic hold;

    decodeIf dc ();

    // no writes leave the core in reset or after ebreak
    assign hold = halt || !arstN;

    fetchUnit u_fetchUnit (
        .clk      (clk),
        .arstN    (arstN),
        .dc       (dc.fch),
        .taken    (taken),
        .target   (target),
        .imemData (imemData),
        .imemAddr (imemAddr),
        .pc       (pc),
        .inst     (inst),
        .halt     (halt)
    );

    instDecoder u_instDecoder (
        .inst (inst),
        .dc   (dc.dec)
    );

    regFile u_regFile (
        .clk    (clk),
        .arstN  (arstN),
        .rs1    (inst[19:15]),
        .rs2    (inst[24:20]),
        .rd     (inst[11:7]),
        .wdata  (rdWdata),
        .wen    (rdWen),
        .rdata1 (rs1Val),
        .rdata2 (rs2Val)
    );

    execUnit u_execUnit (
        .dc        (dc.exe),
        .pc        (pc),
        .rs1Val    (rs1Val),
        .rs2Val    (rs2Val),
        .aluResult (aluResult),
        .taken     (taken),
        .target    (target)
    );

    memWriteback u_memWriteback (
        .dc        (dc.mem),
        .halt      (hold),
        .aluResult (aluResult),
        .pc        (pc),
        .rs2Val    (rs2Val),
        .dmemRdata (dmemRdata),
        .dmemAddr  (dmemAddr),
        .dmemWdata (dmemWdata),
        .dmemWmask (dmemWmask),
        .dmemWen   (dmemWen),
        .rdWdata   (rdWdata),
        .rdWen     (rdWen)
    );

endmodule

//--- verif/rvCoreTb.sv
`include "rvConfig_config.svh"

module rvCoreTb;
    timeunit 1ns;
    timeprecision 1ps;

    logic clk = 1'b0;
    logic arstN = 1'b0;
    rvPkg::xlenT imemAddr, dmemAddr, dmemWdata, pc;
    rvPkg::xlenT imemData = '0;
    rvPkg::xlenT dmemRdata = '0;
    rvPkg::byteMaskT dmemWmask;
    rvPkg::instT inst;
    logic dmemWen, halt;

    logic [63:0] imem [rvPkg::xlenT];
    logic [7:0] dmem [rvPkg::xlenT];
    int loadCount = 0;
    int wrCount = 0;
    rvPkg::xlenT logAddr[$], logData[$], expAddr[$], expData[$];
    rvPkg::byteMaskT logMask[$], expMask[$];
    rvPkg::instT prog[$];
    rvPkg::xlenT refRegs [32];
    rvPkg::xlenT expHaltPc;
    int mismatches = 0;
    int otherErrors = 0;
    int seed = 32'h294b2e09;

    rvCore u_rvCore (
        .clk(clk), .arstN(arstN), .imemAddr(imemAddr), .imemData(imemData),
        .dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemWmask(dmemWmask),
        .dmemWen(dmemWen), .dmemRdata(dmemRdata), .pc(pc), .inst(inst), .halt(halt)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    always @(imemAddr or loadCount) begin
        imemData = imem.exists(imemAddr) ? imem[imemAddr] : 64'h0;
    end

    always @(dmemAddr or wrCount) begin
        for (int i = 0; i < 8; i++) begin
            dmemRdata[8*i +: 8] = dmem.exists(dmemAddr + 64'(i)) ? dmem[dmemAddr + 64'(i)] : 8'h00;
        end
    end

    // byte-masked write with every write logged
    always @(posedge clk) begin
        if (dmemWen) begin
            for (int i = 0; i < 8; i++) begin
                if (dmemWmask[i]) begin
                    dmem[dmemAddr + 64'(i)] = dmemWdata[8*i +: 8];
                end
            end
            logAddr.push_back(dmemAddr);
            logData.push_back(dmemWdata);
            logMask.push_back(dmemWmask);
            wrCount++;
        end
    end

    task automatic checkWord(input string name, input rvPkg::xlenT got, input rvPkg::xlenT exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic checkInst(input string name, input rvPkg::instT got,
                             input rvPkg::instT exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic checkMask(input string name, input rvPkg::byteMaskT got,
                             input rvPkg::byteMaskT exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            mismatches++;
        end
    endtask

    function automatic rvPkg::xlenT sext12(input logic [11:0] imm);
        return {{52{imm[11]}}, imm};
    endfunction

    // RV64I integer semantics for OP, OP-IMM and their word forms
    function automatic rvPkg::xlenT aluRef(input logic [2:0] f3, input logic alt,
                                           input logic word, input rvPkg::xlenT a,
                                           input rvPkg::xlenT b);
        rvPkg::xlenT r;
        rvPkg::xlenT lowA;
        logic [5:0] sh;
        sh = word ? {1'b0, b[4:0]} : b[5:0];
        lowA = word ? {{32{alt & a[31]}}, a[31:0]} : a;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << sh;
            3'd2: r = {63'b0, $signed(a) < $signed(b)};
            3'd3: r = {63'b0, a < b};
            3'd4: r = a ^ b;
            3'd5: r = alt ? rvPkg::xlenT'($signed(lowA) >>> sh) : lowA >> sh;
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return word ? {{32{r[31]}}, r[31:0]} : r;
    endfunction

    function automatic logic branchRef(input logic [2:0] f3, input rvPkg::xlenT a,
                                       input rvPkg::xlenT b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic rvPkg::xlenT curPc();
        return `RV_RESET_PC + 64'(4 * prog.size());
    endfunction

    task automatic beginProgram();
        prog.delete();
        expAddr.delete();
        expData.delete();
        expMask.delete();
        dmem.delete();
        wrCount++;
    endtask

    task automatic aluR(input logic [2:0] f3, input logic alt, input logic word,
                        input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        logic [6:0] op;
        op = word ? rvPkg::opOpW : rvPkg::opOp;
        prog.push_back({alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, op});
        if (rd != 5'd0) refRegs[rd] = aluRef(f3, alt, word, refRegs[rs1], refRegs[rs2]);
    endtask

    task automatic aluI(input logic [2:0] f3, input logic word, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [11:0] imm);
        logic [6:0] op;
        op = word ? rvPkg::opOpImmW : rvPkg::opOpImm;
        prog.push_back({imm, rs1, f3, rd, op});
        if (rd != 5'd0) begin
            refRegs[rd] = aluRef(f3, (f3 == 3'd5) && imm[10], word, refRegs[rs1], sext12(imm));
        end
    endtask

    task automatic lui(input logic [4:0] rd, input logic [19:0] imm);
        prog.push_back({imm, rd, rvPkg::opLui});
        refRegs[rd] = {{32{imm[19]}}, imm, 12'b0};
    endtask

    // live clear means the store sits on a skipped path
    task automatic storeOp(input logic [2:0] f3, input logic [4:0] rs2,
                           input logic [11:0] off, input logic live);
        logic [7:0] sizeMask;
        prog.push_back({off[11:5], rs2, 5'd0, f3, off[4:0], rvPkg::opStore});
        sizeMask = (f3 == 3'd0) ? 8'h01 : (f3 == 3'd1) ? 8'h03 : (f3 == 3'd2) ? 8'h0f : 8'hff;
        if (live) begin
            expAddr.push_back({52'b0, off[11:3], 3'b000});
            expData.push_back(refRegs[rs2] << (8 * off[2:0]));
            expMask.push_back(sizeMask << off[2:0]);
        end
    endtask

    task automatic loadOp(input logic [2:0] f3, input logic [4:0] rd, input logic [11:0] off);
        rvPkg::xlenT raw;
        prog.push_back({off, 5'd0, f3, rd, rvPkg::opLoad});
        for (int i = 0; i < 8; i++) raw[8*i +: 8] = dmem[{52'b0, off} + 64'(i)];
        case (f3[1:0])
            2'd0: refRegs[rd] = {{56{!f3[2] && raw[7]}}, raw[7:0]};
            2'd1: refRegs[rd] = {{48{!f3[2] && raw[15]}}, raw[15:0]};
            2'd2: refRegs[rd] = {{32{!f3[2] && raw[31]}}, raw[31:0]};
            default: refRegs[rd] = raw;
        endcase
    endtask

    task automatic runProgram();
        int cycles;
        expHaltPc = curPc();
        prog.push_back(32'h0010_0073);
        if (prog.size() % 2 == 1) prog.push_back(32'h0000_0013);
        imem.delete();
        for (int k = 0; k < prog.size() / 2; k++) begin
            imem[`RV_RESET_PC + 64'(8 * k)] = {prog[2*k+1], prog[2*k]};
        end
        loadCount++;
        @(posedge clk);
        #5 arstN = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #5;
            checkWord("pc", pc, `RV_RESET_PC);
            checkFlag("dmemWen", dmemWen, 1'b0);
            checkFlag("halt", halt, 1'b0);
        end
        logAddr.delete();
        logData.delete();
        logMask.delete();
        arstN = 1'b1;
        cycles = 0;
        while (!halt && cycles < 200) begin
            @(posedge clk);
            #5;
            cycles++;
        end
        if (!halt) begin
            $display("timeout: halt did not rise within 200 cycles");
            otherErrors++;
        end
        checkWord("pc", pc, expHaltPc);
        checkInst("inst", inst, 32'h0010_0073);
        if (logAddr.size() != expAddr.size()) begin
            $display("wrong number of memory writes: %0d instead of %0d",
                     logAddr.size(), expAddr.size());
            otherErrors++;
        end
        for (int k = 0; k < logAddr.size() && k < expAddr.size(); k++) begin
            checkWord("dmemAddr", logAddr[k], expAddr[k]);
            checkWord("dmemWdata", logData[k], expData[k]);
            checkMask("dmemWmask", logMask[k], expMask[k]);
        end
    endtask

    task automatic testResetHalt();
        beginProgram();
        runProgram();
        checkFlag("halt", halt, 1'b1);
        // a store in place of the ebreak must stay blocked while halted
        imem[`RV_RESET_PC] = {32'h0000_0013, 7'h08, 5'd0, 5'd0, 3'd3, 5'd0, rvPkg::opStore};
        loadCount++;
        repeat (10) begin
            @(posedge clk);
            #5;
            checkWord("pc", pc, expHaltPc);
            checkFlag("halt", halt, 1'b1);
            checkFlag("dmemWen", dmemWen, 1'b0);
        end
        if (logAddr.size() != 0) begin
            $display("memory was written while halted");
            otherErrors++;
        end
        // the same store sits at the reset pc while reset is low
        arstN = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #5;
            checkFlag("dmemWen", dmemWen, 1'b0);
        end
    endtask

    task automatic testAlu();
        beginProgram();
        aluI(3'd0, 1'b0, 5'd1, 5'd0, 12'hb2e);
        aluI(3'd0, 1'b0, 5'd2, 5'd0, 12'd37);
        lui(5'd3, 20'h80000);
        for (int f = 0; f < 10; f++) begin
            aluR(f < 8 ? 3'(f) : (f == 8 ? 3'd0 : 3'd5), f >= 8, 1'b0, 5'd5, 5'd1, 5'd2);
            storeOp(3'd3, 5'd5, 12'h100 + 12'(8 * f), 1'b1);
        end
        for (int f = 0; f < 9; f++) begin
            aluI(f < 8 ? 3'(f) : 3'd5, 1'b0, 5'd6, 5'd3,
                 (f == 1 || f == 5) ? 12'd45 : (f == 8 ? 12'h42d : 12'h8a5));
            storeOp(3'd3, 5'd6, 12'h200 + 12'(8 * f), 1'b1);
        end
        runProgram();
    endtask

    task automatic testWord();
        beginProgram();
        lui(5'd1, 20'h7ffff);
        aluI(3'd0, 1'b0, 5'd1, 5'd1, 12'h7ff);
        aluI(3'd0, 1'b0, 5'd2, 5'd0, 12'd33);
        lui(5'd3, 20'h80000);
        aluI(3'd0, 1'b0, 5'd4, 5'd0, 12'd1);
        aluR(3'd0, 1'b0, 1'b1, 5'd5, 5'd1, 5'd1);
        aluR(3'd0, 1'b1, 1'b1, 5'd6, 5'd3, 5'd4);
        aluI(3'd0, 1'b1, 5'd7, 5'd1, 12'h7ff);
        aluI(3'd0, 1'b1, 5'd7, 5'd7, 12'h7ff);
        aluR(3'd1, 1'b0, 1'b0, 5'd8, 5'd4, 5'd2);
        aluR(3'd1, 1'b0, 1'b1, 5'd9, 5'd4, 5'd2);
        aluR(3'd5, 1'b0, 1'b1, 5'd10, 5'd3, 5'd2);
        aluR(3'd5, 1'b1, 1'b1, 5'd11, 5'd3, 5'd2);
        aluI(3'd1, 1'b1, 5'd12, 5'd1, 12'd3);
        for (int r = 5; r <= 12; r++) storeOp(3'd3, 5'(r), 12'h100 + 12'(8 * r), 1'b1);
        runProgram();
    endtask

    task automatic testLoadStore();
        beginProgram();
        for (int i = 0; i < 8; i++) dmem[64'h200 + 64'(i)] = 8'h81 + 8'(i * 8'h3d);
        lui(5'd1, 20'h89abd);
        aluI(3'd0, 1'b0, 5'd1, 5'd1, 12'hdef);
        for (int o = 0; o < 8; o++) storeOp(3'd0, 5'd1, 12'h300 + 12'(o), 1'b1);
        for (int o = 0; o < 8; o += 2) storeOp(3'd1, 5'd1, 12'h340 + 12'(o), 1'b1);
        for (int o = 0; o < 8; o += 4) storeOp(3'd2, 5'd1, 12'h380 + 12'(o), 1'b1);
        for (int f = 0; f < 7; f++) begin
            if (f != 3) begin
                for (int o = 0; o < 8; o += (1 << (f % 4))) begin
                    loadOp(3'(f), 5'd5, 12'h200 + 12'(o));
                    storeOp(3'd3, 5'd5, 12'h500, 1'b1);
                end
            end
        end
        loadOp(3'd3, 5'd5, 12'h200);
        storeOp(3'd3, 5'd5, 12'h500, 1'b1);
        runProgram();
    endtask

    task automatic testControl();
        logic [2:0] f3;
        logic taken;
        logic [4:0] pairs [3][2];
        pairs = '{'{5'd1, 5'd2}, '{5'd2, 5'd1}, '{5'd2, 5'd3}};
        beginProgram();
        aluI(3'd0, 1'b0, 5'd1, 5'd0, 12'hffd);
        aluI(3'd0, 1'b0, 5'd2, 5'd0, 12'd5);
        aluI(3'd0, 1'b0, 5'd3, 5'd0, 12'd5);
        for (int b = 0; b < 6; b++) begin
            f3 = (b < 2) ? 3'(b) : 3'(b + 2);
            for (int p = 0; p < 3; p++) begin
                aluI(3'd0, 1'b0, 5'd7, 5'd0, 12'(16 * b + 2 * p));
                taken = branchRef(f3, refRegs[pairs[p][0]], refRegs[pairs[p][1]]);
                // branch over the next store
                prog.push_back({7'b0, pairs[p][1], pairs[p][0], f3, 5'b01000, rvPkg::opBranch});
                storeOp(3'd3, 5'd7, 12'h400, !taken);
                aluI(3'd0, 1'b0, 5'd7, 5'd7, 12'd1);
                storeOp(3'd3, 5'd7, 12'h400, 1'b1);
            end
        end
        refRegs[9] = curPc() + 64'd4;
        prog.push_back({1'b0, 10'd4, 1'b0, 8'd0, 5'd9, rvPkg::opJal});
        storeOp(3'd3, 5'd7, 12'h400, 1'b0);
        storeOp(3'd3, 5'd9, 12'h408, 1'b1);
        refRegs[10] = curPc();
        prog.push_back({20'h00000, 5'd10, rvPkg::opAuipc});
        refRegs[11] = curPc() + 64'd4;
        // odd offset checks that bit 0 of the target is dropped
        prog.push_back({12'd13, 5'd10, 3'd0, 5'd11, rvPkg::opJalr});
        storeOp(3'd3, 5'd7, 12'h400, 1'b0);
        storeOp(3'd3, 5'd11, 12'h410, 1'b1);
        runProgram();
    endtask

    task automatic testRandomChains();
        logic [31:0] r;
        for (int c = 0; c < 20; c++) begin
            beginProgram();
            for (int x = 1; x <= 4; x++) begin
                r = $random(seed);
                aluI(3'd0, 1'b0, 5'(x), 5'd0, r[11:0]);
            end
            for (int s = 0; s < 10; s++) begin
                r = $random(seed);
                case (r[1:0])
                    2'd0: aluI(3'd0, 1'b0, 5'd1 + 5'(r[3:2]), 5'd1 + 5'(r[5:4]), r[19:8]);
                    2'd1: aluR(3'd0, 1'b0, 1'b0, 5'd1 + 5'(r[3:2]), 5'd1 + 5'(r[5:4]),
                               5'd1 + 5'(r[7:6]));
                    default: aluR(3'd4, 1'b0, 1'b0, 5'd1 + 5'(r[3:2]), 5'd1 + 5'(r[5:4]),
                                  5'd1 + 5'(r[7:6]));
                endcase
            end
            storeOp(3'd3, 5'd1 + 5'(r[3:2]), 12'h600, 1'b1);
            runProgram();
        end
    endtask

    initial begin
        for (int i = 0; i < 32; i++) refRegs[i] = '0;
        testResetHalt();
        testAlu();
        testWord();
        testLoadStore();
        testControl();
        testRandomChains();
        $display("errors: %0d mismatches, %0d other failures", mismatches, otherErrors);
        if (mismatches == 0 && otherErrors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+hdl
hdl/rvPkg.sv
hdl/decodeIf.sv
hdl/fetchUnit.sv
hdl/instDecoder.sv
hdl/regFile.sv
hdl/execUnit.sv
hdl/memWriteback.sv
hdl/rvCore.sv
verif/rvCoreTb.sv

//--- run.sh
#!/bin/sh
# compile and run the rvCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module rvCoreTb -f build.f -Mdir obj_dir -o rvCoreTb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/rvCoreTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
